// File: rtl/lspcPkg.sv
// Shared widths and register offsets; VRAM is one flat 64K-word space with no slow/fast zones
`default_nettype none

package lspcPkg;

	// ====================
	// Bus and VRAM widths
	// ====================

	// CPU data and VRAM word
	typedef logic [15:0] wordT;

	// Flat word address, full 16-bit range
	typedef logic [15:0] vramAddrT;
	localparam int VRAM_WORDS = 65536;

	// CPU address bits 3:1
	typedef logic [2:0] regSelT;

	// Register offsets
	localparam regSelT REG_VRAMADDR = 3'd0;
	localparam regSelT REG_VRAMRW   = 3'd1;
	localparam regSelT REG_VRAMMOD  = 3'd2;
	localparam regSelT REG_LSPCMODE = 3'd3;

	// ====================
	// Auto-animation
	// ====================

	typedef logic [2:0] aaCountT;
	// Frames per step minus one
	typedef logic [7:0] aaSpeedT;

	// Field positions inside the mode word
	localparam int AA_SPEED_LSB   = 8;
	localparam int AA_DISABLE_BIT = 3;

	// ====================
	// Sprite fields
	// ====================

	typedef logic [8:0]  rasterT;
	typedef logic [19:0] tileT;
	typedef logic [7:0]  yShrinkT;
	// Only bits 0 and 5 matter for the 33-tile case
	typedef logic [5:0]  sprSizeT;
	typedef logic [7:0]  lineT;
	typedef logic [15:0] loRomAddrT;

endpackage

`default_nettype wire

// File: rtl/cpuRegs.sv
// cpuRd must never overlap cpuWr; read data is combinational and zero while cpuRd is low
`timescale 1ns/1ns
`default_nettype none

module cpuRegs (
	input  wire                     CLK,
	input  wire                     T73A_OUT,
	input  wire lspcPkg::regSelT    regSel,
	input  wire lspcPkg::wordT      wrData,
	input  wire                     cpuWr,
	input  wire                     cpuRd,
	output lspcPkg::wordT           cpuRdData,
	input  wire lspcPkg::wordT      vramRdData,
	input  wire lspcPkg::rasterT    raster,
	input  wire lspcPkg::aaCountT   aaCount,
	output logic                    addrLoad,
	output lspcPkg::vramAddrT       addrValue,
	output lspcPkg::wordT           modValue,
	output logic                    writeReq,
	output lspcPkg::wordT           writeData,
	output lspcPkg::aaSpeedT        aaSpeed,
	output logic                    aaDisable
);
	import lspcPkg::*;

	// ====================
	// Write decode
	// ====================

	// Each strobe turns into a one-cycle pulse or a held field
	always_ff @(posedge CLK or negedge T73A_OUT) begin
		if (!T73A_OUT) begin
			addrLoad  <= 1'b0;
			addrValue <= '0;
			modValue  <= '0;
			writeReq  <= 1'b0;
			writeData <= '0;
			aaSpeed   <= '0;
			aaDisable <= 1'b0;
		end else begin
			// Pulses drop again unless re-strobed
			addrLoad <= 1'b0;
			writeReq <= 1'b0;
			if (cpuWr) begin
				case (regSel)
					REG_VRAMADDR: begin
						// Address taken by vramPort one edge later
						addrLoad  <= 1'b1;
						addrValue <= vramAddrT'(wrData);
					end
					REG_VRAMRW: begin
						// Data latch plus write request
						writeReq  <= 1'b1;
						writeData <= wrData;
					end
					REG_VRAMMOD: begin
						modValue <= wrData;
					end
					REG_LSPCMODE: begin
						// Speed in the high byte
						aaSpeed   <= wrData[AA_SPEED_LSB +: $bits(aaSpeedT)];
						aaDisable <= wrData[AA_DISABLE_BIT];
					end
					default: begin
						// Unmapped offsets ignored
					end
				endcase
			end
		end
	end

	// ====================
	// Read mux
	// ====================

	always_comb begin
		cpuRdData = '0;
		if (cpuRd) begin
			case (regSel)
				// Both VRAM offsets return the word at the current address
				REG_VRAMADDR, REG_VRAMRW: cpuRdData = vramRdData;
				REG_VRAMMOD:              cpuRdData = modValue;
				// Raster line on top, count at the bottom
				REG_LSPCMODE:             cpuRdData = {raster, 4'b0000, aaCount};
				default:                  cpuRdData = '0;
			endcase
		end
	end

	// Bus never reads and writes in the same cycle
	assert property (@(posedge CLK) disable iff (!T73A_OUT) !(cpuRd && cpuWr))
		else $error("cpuRd and cpuWr high together");

endmodule

`default_nettype wire

// File: rtl/vramPort.sv
// No back-pressure; addrLoad and writeReq must not coincide and memWe follows writeReq directly
`timescale 1ns/1ns
`default_nettype none

module vramPort (
	input  wire                     CLK,
	input  wire                     T73A_OUT,
	input  wire                     addrLoad,
	input  wire lspcPkg::vramAddrT  addrValue,
	input  wire lspcPkg::wordT      modValue,
	input  wire                     writeReq,
	input  wire lspcPkg::wordT      writeData,
	output lspcPkg::vramAddrT       memAddr,
	output logic                    memWe,
	output lspcPkg::wordT           memWrData
);
	import lspcPkg::*;

	// Current CPU-side VRAM address
	vramAddrT curAddr;
	// Address after the modulo step
	vramAddrT nextAddr;

	// ====================
	// Address stepping
	// ====================

	// Wraps at 64K words
	assign nextAddr = curAddr + vramAddrT'(modValue);

	always_ff @(posedge CLK or negedge T73A_OUT) begin
		if (!T73A_OUT) begin
			curAddr <= '0;
		end else if (addrLoad) begin
			// Direct load from the address register
			curAddr <= addrValue;
		end else if (writeReq) begin
			// Step lands on the same edge as the array write
			curAddr <= nextAddr;
		end
	end

	// ====================
	// Memory side
	// ====================

	// Write happens at the old address
	assign memAddr   = curAddr;
	assign memWe     = writeReq;
	assign memWrData = writeData;

	// cpuRegs issues at most one of these per strobe
	assert property (@(posedge CLK) disable iff (!T73A_OUT) !(addrLoad && writeReq))
		else $error("addrLoad and writeReq high together");

endmodule

`default_nettype wire

// File: rtl/vramArray.sv
// Contents are undefined until written; read data is one edge behind memAddr and shows the old word
`timescale 1ns/1ns
`default_nettype none

module vramArray (
	input  wire                     CLK,
	input  wire lspcPkg::vramAddrT  memAddr,
	input  wire                     memWe,
	input  wire lspcPkg::wordT      memWrData,
	output lspcPkg::wordT           memRdData
);
	import lspcPkg::*;

	// Flat word store
	wordT mem [VRAM_WORDS];

	// ====================
	// Single port
	// ====================

	// Read sees the word before any write on the same edge
	always_ff @(posedge CLK) begin
		if (memWe) begin
			mem[memAddr] <= memWrData;
		end
		memRdData <= mem[memAddr];
	end

endmodule

`default_nettype wire

// File: rtl/autoAnim.sv
// Lowering aaSpeed below the running frame count lets the divider run on to its wrap first
`timescale 1ns/1ns
`default_nettype none

module autoAnim (
	input  wire                     CLK,
	input  wire                     T73A_OUT,
	input  wire                     frameStart,
	input  wire lspcPkg::aaSpeedT   aaSpeed,
	input  wire                     aaDisable,
	input  wire lspcPkg::tileT      sprTile,
	input  wire                     sprAa2,
	input  wire                     sprAa3,
	output lspcPkg::aaCountT        aaCount,
	output lspcPkg::tileT           animTile
);
	import lspcPkg::*;

	// Frames since the last step
	aaSpeedT frameCnt;
	// Substitution enables
	logic aa3En;
	logic aa2En;

	// ====================
	// Frame divider
	// ====================

	// Keeps counting while animation is disabled
	always_ff @(posedge CLK or negedge T73A_OUT) begin
		if (!T73A_OUT) begin
			frameCnt <= '0;
			aaCount  <= '0;
		end else if (frameStart) begin
			if (frameCnt == aaSpeed) begin
				frameCnt <= '0;
				// Wraps at 8
				aaCount  <= aaCount + 1'b1;
			end else begin
				frameCnt <= frameCnt + 1'b1;
			end
		end
	end

	// ====================
	// Tile substitution
	// ====================

	assign aa3En = sprAa3 & ~aaDisable;
	// aa3 implies the two low bits as well
	assign aa2En = (sprAa2 | sprAa3) & ~aaDisable;

	assign animTile[19:3] = sprTile[19:3];
	assign animTile[2]    = aa3En ? aaCount[2] : sprTile[2];
	assign animTile[1:0]  = aa2En ? aaCount[1:0] : sprTile[1:0];

	// Count only moves on the edge that sampled a frame pulse
	assert property (@(posedge CLK) disable iff (!T73A_OUT) $changed(aaCount) |-> $past(frameStart))
		else $error("aaCount changed without frameStart");

endmodule

`default_nettype wire

// File: rtl/sprLineCalc.sv
// Outputs lag inputs by one clock; raster bit 8 and size bits 4:1 play no part
`timescale 1ns/1ns
`default_nettype none

module sprLineCalc (
	input  wire                     CLK,
	input  wire                     T73A_OUT,
	input  wire lspcPkg::rasterT    raster,
	input  wire                     flip,
	input  wire lspcPkg::rasterT    sprY,
	input  wire lspcPkg::yShrinkT   yShrink,
	input  wire lspcPkg::sprSizeT   sprSize,
	output lspcPkg::loRomAddrT      loRomAddr,
	output logic                    sprContinuous
);
	import lspcPkg::*;

	lineT       lookahead;
	logic [8:0] ySum;
	logic       topHalf;
	lineT       lineA;
	logic [8:0] shrinkSum;
	logic       contNext;
	lineT       lineB;
	lineT       loLine;

	// ====================
	// Line position
	// ====================

	// Next line, with field parity in the low bit
	assign lookahead = {raster[7:1], flip} + 1'b1;
	assign ySum      = {1'b0, lookahead} + {1'b0, sprY[7:0]};
	// Carry agrees with sprY bit 8 in the upper half
	assign topHalf   = (sprY[8] == ySum[8]);
	// Lower half mirrored
	assign lineA     = topHalf ? ySum[7:0] : ~ySum[7:0];

	// ====================
	// 33-tile case
	// ====================

	// Line runs past the shrunk height
	assign shrinkSum = {1'b0, lineA} + {1'b0, ~yShrink};
	assign contNext  = sprSize[0] & sprSize[5] & shrinkSum[8];
	assign lineB     = lineA + {~yShrink[6:0], 1'b0};
	assign loLine    = contNext ? ~lineB : lineA;

	// Single register stage
	always_ff @(posedge CLK or negedge T73A_OUT) begin
		if (!T73A_OUT) begin
			loRomAddr     <= '0;
			sprContinuous <= 1'b0;
		end else begin
			// Shrink value selects the ROM page
			loRomAddr     <= {yShrink, loLine};
			sprContinuous <= contNext;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lspcTop.sv
// Single clock domain; raster and frameStart come from outside and VRAM lives inside the core
`timescale 1ns/1ns
`default_nettype none

module lspcTop (
	input  wire                     CLK,
	input  wire                     T73A_OUT,
	input  wire lspcPkg::regSelT    regSel,
	input  wire lspcPkg::wordT      wrData,
	input  wire                     cpuWr,
	input  wire                     cpuRd,
	output lspcPkg::wordT           cpuRdData,
	input  wire lspcPkg::rasterT    raster,
	input  wire                     frameStart,
	input  wire lspcPkg::tileT      sprTile,
	input  wire                     sprAa2,
	input  wire                     sprAa3,
	output lspcPkg::tileT           animTile,
	input  wire                     flip,
	input  wire lspcPkg::rasterT    sprY,
	input  wire lspcPkg::yShrinkT   yShrink,
	input  wire lspcPkg::sprSizeT   sprSize,
	output lspcPkg::loRomAddrT      loRomAddr,
	output logic                    sprContinuous
);
	import lspcPkg::*;

	// Register block to address port
	logic     addrLoad;
	vramAddrT addrValue;
	wordT     modValue;
	logic     writeReq;
	wordT     writeData;
	// Port to memory
	vramAddrT memAddr;
	logic     memWe;
	wordT     memWrData;
	wordT     vramRdData;
	// Animation control and status
	aaSpeedT  aaSpeed;
	logic     aaDisable;
	aaCountT  aaCount;

	// ====================
	// CPU side
	// ====================

	cpuRegs regs (
		.CLK(CLK), .T73A_OUT(T73A_OUT),
		.regSel(regSel), .wrData(wrData), .cpuWr(cpuWr), .cpuRd(cpuRd),
		.cpuRdData(cpuRdData), .vramRdData(vramRdData), .raster(raster), .aaCount(aaCount),
		.addrLoad(addrLoad), .addrValue(addrValue), .modValue(modValue),
		.writeReq(writeReq), .writeData(writeData),
		.aaSpeed(aaSpeed), .aaDisable(aaDisable)
	);

	vramPort port (
		.CLK(CLK), .T73A_OUT(T73A_OUT),
		.addrLoad(addrLoad), .addrValue(addrValue), .modValue(modValue),
		.writeReq(writeReq), .writeData(writeData),
		.memAddr(memAddr), .memWe(memWe), .memWrData(memWrData)
	);

	vramArray vram (
		.CLK(CLK), .memAddr(memAddr), .memWe(memWe),
		.memWrData(memWrData), .memRdData(vramRdData)
	);

	// ====================
	// Sprite side
	// ====================

	autoAnim anim (
		.CLK(CLK), .T73A_OUT(T73A_OUT), .frameStart(frameStart),
		.aaSpeed(aaSpeed), .aaDisable(aaDisable),
		.sprTile(sprTile), .sprAa2(sprAa2), .sprAa3(sprAa3),
		.aaCount(aaCount), .animTile(animTile)
	);

	sprLineCalc lineCalc (
		.CLK(CLK), .T73A_OUT(T73A_OUT),
		.raster(raster), .flip(flip), .sprY(sprY), .yShrink(yShrink), .sprSize(sprSize),
		.loRomAddr(loRomAddr), .sprContinuous(sprContinuous)
	);

endmodule

`default_nettype wire

// File: verif/tbClock.sv
// Free-running clock, 4 ns period, starts low at time zero and never stops by itself
`timescale 1ns/1ns
`default_nettype none

module tbClock (
	output logic CLK
);
	// Half of the 4 ns period
	localparam int HALF_NS = 2;

	initial begin
		CLK = 1'b0;
		forever begin
			#HALF_NS;
			CLK = ~CLK;
		end
	end

endmodule

`default_nettype wire

// File: verif/lspcTb.sv
// Runs from the project root to find verif/lspcTests.txt; stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

module lspcTb;
	import lspcPkg::*;

	localparam int RESET_CYCLES  = 8;
	localparam int CYCLES_PER_OP = 12;
	localparam int PERIOD_NS     = 4;
	// Hex fields per line after the opcode
	localparam int ARGS          = 7;
	localparam string TEST_FILE  = "verif/lspcTests.txt";

	logic      CLK;
	logic      T73A_OUT;
	regSelT    regSel;
	wordT      wrData;
	logic      cpuWr;
	logic      cpuRd;
	wordT      cpuRdData;
	rasterT    raster;
	logic      frameStart;
	tileT      sprTile;
	logic      sprAa2;
	logic      sprAa3;
	tileT      animTile;
	logic      flip;
	rasterT    sprY;
	yShrinkT   yShrink;
	sprSizeT   sprSize;
	loRomAddrT loRomAddr;
	logic      sprContinuous;

	// Parsed tests, ARGS words per operation
	byte         opQ[$];
	logic [31:0] argQ[$];
	int          frameTotal = 0;
	integer      seed;
	bit          loaded = 1'b0;

	tbClock clkGen (.CLK(CLK));

	lspcTop UUT (
		.CLK(CLK), .T73A_OUT(T73A_OUT),
		.regSel(regSel), .wrData(wrData), .cpuWr(cpuWr), .cpuRd(cpuRd), .cpuRdData(cpuRdData),
		.raster(raster), .frameStart(frameStart),
		.sprTile(sprTile), .sprAa2(sprAa2), .sprAa3(sprAa3), .animTile(animTile),
		.flip(flip), .sprY(sprY), .yShrink(yShrink), .sprSize(sprSize),
		.loRomAddr(loRomAddr), .sprContinuous(sprContinuous)
	);

	// ====================
	// Checks
	// ====================

	task automatic stopRun();
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkTile(input string name, input tileT actual, input tileT expected);
		if (actual !== expected) begin
			$display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkLine(input loRomAddrT addr, input logic cont,
		input loRomAddrT expAddr, input logic expCont);
		if (addr !== expAddr) begin
			$display("Fail at %0d ns: loRomAddr is %h, expected %h", $time, addr, expAddr);
			stopRun();
		end
		if (cont !== expCont) begin
			$display("Fail at %0d ns: sprContinuous is %b, expected %b", $time, cont, expCont);
			stopRun();
		end
	endtask

	// ====================
	// Operations
	// ====================

	// Strobe at edge N, load or write at N+1, read data settled after N+2
	task automatic regWrite(input regSelT sel, input wordT data);
		regSel = sel;
		wrData = data;
		cpuWr  = 1'b1;
		@(negedge CLK);
		cpuWr  = 1'b0;
		repeat (2) @(negedge CLK);
	endtask

	// Read mux is combinational
	task automatic regRead(input regSelT sel, input wordT expected);
		regSel = sel;
		cpuRd  = 1'b1;
		@(negedge CLK);
		checkWord("cpuRdData", cpuRdData, expected);
		cpuRd  = 1'b0;
	endtask

	// One-cycle pulses with a low cycle between them
	task automatic framePulses(input int count);
		repeat (count) begin
			frameStart = 1'b1;
			@(negedge CLK);
			frameStart = 1'b0;
			@(negedge CLK);
		end
	endtask

	task automatic tileCheck(input tileT tile, input logic aa2, input logic aa3,
		input tileT expected);
		sprTile = tile;
		sprAa2  = aa2;
		sprAa3  = aa3;
		@(negedge CLK);
		checkTile("animTile", animTile, expected);
	endtask

	// Registered once, so look one edge later
	task automatic lineCheck(input rasterT line, input logic fl, input rasterT y,
		input yShrinkT shrink, input sprSizeT size, input loRomAddrT expAddr,
		input logic expCont);
		raster  = line;
		flip    = fl;
		sprY    = y;
		yShrink = shrink;
		sprSize = size;
		@(negedge CLK);
		checkLine(loRomAddr, sprContinuous, expAddr, expCont);
	endtask

	task automatic idleGap();
		int gap;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(negedge CLK);
	endtask

	// ====================
	// Test file
	// ====================

	function automatic logic [31:0] opArg(input int i, input int k);
		return argQ[i * ARGS + k];
	endfunction

	task automatic loadTests();
		int fd;
		int n;
		string line;
		string body;
		byte op;
		logic [31:0] a [ARGS];
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the test file %s", TEST_FILE);
			stopRun();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Skip comments and blank lines
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				for (int k = 0; k < ARGS; k++) begin
					a[k] = '0;
				end
				op = line.getc(0);
				body = line.substr(1, line.len() - 1);
				n = $sscanf(body, "%h %h %h %h %h %h %h",
					a[0], a[1], a[2], a[3], a[4], a[5], a[6]);
				opQ.push_back(op);
				for (int k = 0; k < ARGS; k++) begin
					argQ.push_back(a[k]);
				end
				if (op == "F") begin
					frameTotal += int'(a[0]);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic runOp(input int i);
		byte op;
		op = opQ[i];
		case (op)
			"W": regWrite(regSelT'(opArg(i, 0)), wordT'(opArg(i, 1)));
			"R": regRead(regSelT'(opArg(i, 0)), wordT'(opArg(i, 1)));
			"F": framePulses(int'(opArg(i, 0)));
			"T": tileCheck(tileT'(opArg(i, 0)), opArg(i, 1) != 0, opArg(i, 2) != 0,
				tileT'(opArg(i, 3)));
			"L": lineCheck(rasterT'(opArg(i, 0)), opArg(i, 1) != 0, rasterT'(opArg(i, 2)),
				yShrinkT'(opArg(i, 3)), sprSizeT'(opArg(i, 4)), loRomAddrT'(opArg(i, 5)),
				opArg(i, 6) != 0);
			default: begin
				$display("Unknown operation %c in test line %0d", op, i);
				stopRun();
			end
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		seed       = 25860;
		T73A_OUT   = 1'b0;
		regSel     = '0;
		wrData     = '0;
		cpuWr      = 1'b0;
		cpuRd      = 1'b0;
		raster     = '0;
		frameStart = 1'b0;
		sprTile    = '0;
		sprAa2     = 1'b0;
		sprAa3     = 1'b0;
		flip       = 1'b0;
		sprY       = '0;
		yShrink    = '0;
		sprSize    = '0;
		loadTests();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge CLK);
		T73A_OUT = 1'b1;
		@(negedge CLK);
		foreach (opQ[i]) begin
			runOp(i);
			idleGap();
		end
		$display("Everything OK");
		$finish;
	end

	// Budget scales with the number of operations and frame pulses
	initial begin
		longint limit;
		wait (loaded);
		limit = (longint'(opQ.size()) * CYCLES_PER_OP + 2 * frameTotal + RESET_CYCLES)
			* PERIOD_NS;
		#(limit);
		$display("Watchdog expired after %0d ns with tests still running", limit);
		stopRun();
	end

endmodule

`default_nettype wire

// File: verif/lspcTests.txt
# W sel data | R sel expected | F pulses | T tile aa2 aa3 expected   (hex fields)
# L raster flip sprY yShrink size expLoRomAddr expContinuous          (hex fields)
R 2 0000
R 3 0000
W 0 0100
W 2 0001
W 1 1111
W 1 2222
W 1 3333
W 0 0100
R 1 1111
W 0 0101
R 0 2222
W 0 0102
R 1 3333
W 0 0200
W 2 0020
W 1 A001
W 1 A002
W 0 0220
R 1 A002
W 0 0200
R 0 A001
W 0 FFF0
W 2 0018
W 1 B001
W 1 B002
R 2 0018
W 0 0008
R 1 B002
W 0 FFF0
R 1 B001
W 3 0200
F 2
R 3 0000
F 1
R 3 0001
F 0F
R 3 0006
F 6
R 3 0000
F 0F
R 3 0005
T 12348 0 0 12348
T 12348 1 0 12349
T 12348 0 1 1234D
T 12348 1 1 1234D
W 3 0208
T 12348 1 1 12348
F 3
R 3 0006
W 3 0200
T 12348 1 0 1234A
L 020 0 010 FF 02 FF31 0
L 035 1 0F0 80 01 80D9 0
L 010 0 110 40 20 40DE 0
L 035 1 0F0 80 21 8028 1
L 000 0 002 F0 21 F003 0
L 0F3 0 000 3C 3F 3C86 1
L 1FF 1 105 00 21 0007 1
R 3 FF86

// File: src.f
rtl/lspcPkg.sv
rtl/cpuRegs.sv
rtl/vramPort.sv
rtl/vramArray.sv
rtl/autoAnim.sv
rtl/sprLineCalc.sv
rtl/lspcTop.sv
verif/tbClock.sv
verif/lspcTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lspcTb
FILELIST = src.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)
